// File: hdl/fetchPkg.sv
// Shared types for the branch and PC front end
// Word types, branch opcodes, forwarding select and the command and item records
package fetchPkg;

   // Data or instruction word
   typedef logic [31:0] dataWord;

   // Word address, byte address without its two low bits
   typedef logic [29:0] pcWord;

   // Major opcode and register field
   typedef logic [5:0] opcodeT;
   typedef logic [4:0] regAddr;

   // Unconditional branch, register and immediate forms
   localparam opcodeT opBru  = 6'o46;
   localparam opcodeT opBrui = 6'o56;

   // Conditional branch, register and immediate forms
   localparam opcodeT opBcc  = 6'o47;
   localparam opcodeT opBcci = 6'o57;

   // Return with delay slot
   localparam opcodeT opRtd  = 6'o55;

   // Immediate prefix for the next instruction
   localparam opcodeT opImm  = 6'o54;

   // Source of the compared operand
   typedef enum logic [1:0] {
      fwdReg  = 2'd0,   // register file read
      fwdAlu  = 2'd1,   // ALU result of the instruction ahead
      fwdLoad = 2'd2    // load data of the instruction ahead
   } fwdSel;

   // One command from the execute side
   typedef struct packed {
      opcodeT  opc;
      regAddr  rd;
      regAddr  ra;
      fwdSel   fwd;
      dataWord regA;
      dataWord aluResult;
      dataWord loadData;
      pcWord   target;
   } branchCmd;

   // One fetched slot as seen by the consumer
   typedef struct packed {
      pcWord   pc;
      pcWord   pcLink;
      dataWord instr;
      logic    boundary;
   } fetchItem;

endpackage

// File: hdl/branchCond.sv
// Branch condition decode for one execute command
// Forwards the compared operand, tests it against zero, flags taken, delay and imm
`timescale 1ns/1ps

module branchCond
   import fetchPkg::*;
(
   input  branchCmd cmd,
   output logic     taken,
   output logic     delay,
   output logic     prefix
);

   dataWord opA;
   logic    isZero;
   logic    isNeg;
   logic    condOk;
   logic    isBru;
   logic    isBcc;
   logic    isRtd;

   // Compared operand picked by the forwarding select
   always_comb begin
      case (cmd.fwd)
         fwdAlu:  opA = cmd.aluResult;
         fwdLoad: opA = cmd.loadData;
         default: opA = cmd.regA;
      endcase
   end

   // Signed test against zero only needs these two
   assign isZero = (opA == 32'd0);
   assign isNeg  = opA[31];

   // Condition code sits in rd[2:0]
   always_comb begin
      case (cmd.rd[2:0])
         3'd0:    condOk = isZero;              // eq
         3'd1:    condOk = !isZero;             // ne
         3'd2:    condOk = isNeg;               // lt
         3'd3:    condOk = isNeg || isZero;     // le
         3'd4:    condOk = !isNeg && !isZero;   // gt
         3'd5:    condOk = !isNeg;              // ge
         default: condOk = 1'b0;                // codes 6 and 7 never branch
      endcase
   end

   // Opcode classes
   assign isBru = (cmd.opc == opBru) || (cmd.opc == opBrui);
   assign isBcc = (cmd.opc == opBcc) || (cmd.opc == opBcci);
   assign isRtd = (cmd.opc == opRtd);

   // Unconditional and return always go, conditional only when the test holds
   assign taken = isBru || isRtd || (isBcc && condOk);

   // Delay bit lives in ra for bru and in rd for bcc
   assign delay = (isBru && cmd.ra[4]) || (isBcc && cmd.rd[4]) || isRtd;

   assign prefix = (cmd.opc == opImm);

   // Execute side must never send the spare select code
   always_comb begin
      if (!$isunknown(cmd.fwd)) begin
         assert (cmd.fwd != 2'b11)
            else $error("branchCond: reserved forwarding select %b", cmd.fwd);
      end
   end

endmodule

// File: hdl/branchPcUnit.sv
// Branch and PC pipeline unit
// Resolves each command, steers the fetch PC, and tags slots with kill and boundary flags
`timescale 1ns/1ps

module branchPcUnit
   import fetchPkg::*;
(
   input  logic     gclk,
   input  logic     grst,
   input  logic     stepEn,
   input  branchCmd cmd,
   output pcWord    fetchAddr,
   output pcWord    pc,
   output pcWord    pcLink,
   output logic     skip,
   output logic     boundary
);

   logic  taken;
   logic  delay;
   logic  prefix;

   // Taken flag of the previous step
   logic  takenR;

   pcWord fetchPc;
   pcWord nextFetch;
   logic  skipNext;
   logic  atomBreak;
   logic  boundaryNext;

   branchCond cond0 (
      .cmd    (cmd),
      .taken  (taken),
      .delay  (delay),
      .prefix (prefix)
   );

   // Next state of the PC pipeline
   // Taken branch redirects fetch, otherwise one word on
   assign nextFetch = taken ? cmd.target : fetchPc + 30'd1;

   // ROM reads the current fetch PC in the same step
   assign fetchAddr = fetchPc;

   // Own slot dies on a branch with no delay slot,
   // and the slot after any taken branch is wrong path
   assign skipNext = (taken && !delay) || takenR;

   // imm, rtd, bru and a taken bcc all break the atomic run
   // A killed command behaves like a no-op here
   assign atomBreak    = (taken || prefix) && !skipNext;
   assign boundaryNext = !(atomBreak || takenR);

   // Everything advances together on a step, back-pressure freezes it all
   always_ff @(posedge gclk) begin
      if (grst) begin
         fetchPc  <= '0;
         pc       <= '0;
         pcLink   <= '0;
         takenR   <= 1'b0;
         skip     <= 1'b0;
         boundary <= 1'b0;
      end else if (stepEn) begin
         fetchPc  <= nextFetch;
         pc       <= fetchPc;
         pcLink   <= pc;
         takenR   <= taken;
         skip     <= skipNext;
         boundary <= boundaryNext;
      end
   end

   // PC only moves on a step
   pcFrozen: assert property (@(posedge gclk) disable iff (grst)
      !stepEn |=> $stable(pc))
      else $error("branchPcUnit: pc moved without a step");

   // Two kills in a row need a taken branch in one of the two steps
   skipPairs: assert property (@(posedge gclk) disable iff (grst)
      stepEn && skip && !takenR && !taken |=> !skip)
      else $error("branchPcUnit: back-to-back kill with no taken branch");

endmodule

// File: hdl/instrRom.sv
// Instruction ROM, word addressed, one cycle read latency
// Loaded from program.hex, addresses wrap at the ROM depth
`timescale 1ns/1ps

module instrRom
   import fetchPkg::*;
#(
   parameter int romDepth = 64
) (
   input  logic    gclk,
   input  logic    addrEn,
   input  pcWord   addr,
   output dataWord data
);

   localparam int idxW = (romDepth > 1) ? $clog2(romDepth) : 1;

   dataWord          mem [romDepth];
   logic [idxW-1:0]  romIdx;

   initial begin
      $readmemh("program.hex", mem);
   end

   // Wrap modulo the depth, so odd depths work too
   assign romIdx = idxW'({2'b00, addr} % romDepth);

   // Read word held while the step is frozen
   always_ff @(posedge gclk) begin
      if (addrEn) begin
         data <= mem[romIdx];
      end
   end

endmodule

// File: hdl/fetchOutput.sv
// Output stage of the front end
// Lines fetched words up with their kill and boundary flags, queues two items
`timescale 1ns/1ps

module fetchOutput
   import fetchPkg::*;
(
   input  logic     gclk,
   input  logic     grst,
   input  pcWord    slotPc,
   input  pcWord    slotLink,
   input  logic     slotSkip,
   input  logic     slotBoundary,
   input  dataWord  romData,
   output logic     outValid,
   input  logic     outReady,
   output fetchItem outItem,
   output logic     stepEn
);

   // PC, link and word held one step, flags of the deciding step arrive then
   pcWord    heldPc;
   pcWord    heldLink;
   dataWord  heldData;

   // slotVld marks a real fetch behind slotPc, heldVld the same one step on
   logic     slotVld;
   logic     heldVld;

   fetchItem queue [2];
   logic     wrPtr;
   logic     rdPtr;
   logic [1:0] count;

   fetchItem newItem;
   logic     pushEn;
   logic     popEn;

   // Room for the slot coming back means at most one entry in use
   assign stepEn = (count <= 2'd1);

   assign newItem = '{pc: heldPc, pcLink: heldLink, instr: heldData, boundary: slotBoundary};

   // Killed slots never enter the queue
   assign pushEn = stepEn && heldVld && !slotSkip;
   assign popEn  = outValid && outReady;

   assign outValid = (count != 2'd0);
   assign outItem  = queue[rdPtr];

   always_ff @(posedge gclk) begin
      if (grst) begin
         slotVld <= 1'b0;
         heldVld <= 1'b0;
         wrPtr   <= 1'b0;
         rdPtr   <= 1'b0;
         count   <= 2'd0;
      end else begin
         if (stepEn) begin
            slotVld <= 1'b1;
            heldVld <= slotVld;
         end
         if (pushEn) begin
            wrPtr <= !wrPtr;
         end
         if (popEn) begin
            rdPtr <= !rdPtr;
         end
         count <= count + {1'b0, pushEn} - {1'b0, popEn};
      end
   end

   // Payload side
   always_ff @(posedge gclk) begin
      if (stepEn) begin
         heldPc   <= slotPc;
         heldLink <= slotLink;
         heldData <= romData;
      end
      if (pushEn) begin
         queue[wrPtr] <= newItem;
      end
   end

   // Item must not change under a stalled consumer
   outHeld: assert property (@(posedge gclk) disable iff (grst)
      outValid && !outReady |=> outValid && $stable(outItem))
      else $error("fetchOutput: item changed while stalled");

endmodule

// File: hdl/branchFrontEnd.sv
// Branch and fetch front end, top level
// Command in, PC unit steering the ROM, fetched items out on valid/ready
`timescale 1ns/1ps

module branchFrontEnd
   import fetchPkg::*;
#(
   parameter int romDepth = 64
) (
   input  logic     gclk,
   input  logic     grst,
   input  logic     cmdValid,
   input  branchCmd cmd,
   output logic     cmdReady,
   output logic     outValid,
   output fetchItem outItem,
   input  logic     outReady
);

   branchCmd stepCmd;
   pcWord    fetchAddr;
   pcWord    pc;
   pcWord    pcLink;
   logic     skip;
   logic     boundary;
   dataWord  romData;
   logic     stepEn;

   // Empty step runs an all-zero command, opcode 0 matches no branch
   assign stepCmd  = cmdValid ? cmd : '0;
   assign cmdReady = stepEn;

   branchPcUnit pcUnit0 (
      .gclk      (gclk),
      .grst      (grst),
      .stepEn    (stepEn),
      .cmd       (stepCmd),
      .fetchAddr (fetchAddr),
      .pc        (pc),
      .pcLink    (pcLink),
      .skip      (skip),
      .boundary  (boundary)
   );

   instrRom #(
      .romDepth (romDepth)
   ) rom0 (
      .gclk   (gclk),
      .addrEn (stepEn),
      .addr   (fetchAddr),
      .data   (romData)
   );

   fetchOutput outStage0 (
      .gclk         (gclk),
      .grst         (grst),
      .slotPc       (pc),
      .slotLink     (pcLink),
      .slotSkip     (skip),
      .slotBoundary (boundary),
      .romData      (romData),
      .outValid     (outValid),
      .outReady     (outReady),
      .outItem      (outItem),
      .stepEn       (stepEn)
   );

endmodule

// File: tb/frontEndTb.sv
// Testbench for the branch and fetch front end
// Applies a command table under random back-pressure and checks every item
`timescale 1ns/1ps

module frontEndTb
   import fetchPkg::*;
();

   localparam int romDepth = 24;
   localparam int ixW = $clog2(romDepth);
   localparam int stepLimit = 200;
   localparam dataWord zeroV = 32'h0000_0000;
   localparam dataWord posV = 32'h0000_1234;
   localparam dataWord negV = 32'h8000_0040;

   logic     gclk;
   logic     grst;
   logic     cmdValid;
   branchCmd cmd;
   logic     cmdReady;
   logic     outValid;
   fetchItem outItem;
   logic     outReady;

   integer   seed;
   logic     draining;
   logic     timedOut;
   int       checkErrs;
   int       timeoutErrs;
   int       readyLowCycles;
   int       acceptCount;
   int       checkedCount;
   int       drainGoal;

   dataWord  romImage [romDepth];
   branchCmd cmdTbl [$];
   logic     takenTbl [$];
   fetchItem expQ [$];

   // Model PCs for the next fetch, the step's pc and its link, plus last step's taken flag
   pcWord    mFetch;
   pcWord    mPc;
   pcWord    mLink;
   logic     mTakenPrev;
   logic     mFirstStep;

   branchFrontEnd #(
      .romDepth (romDepth)
   ) dut0 (
      .gclk     (gclk),
      .grst     (grst),
      .cmdValid (cmdValid),
      .cmd      (cmd),
      .cmdReady (cmdReady),
      .outValid (outValid),
      .outItem  (outItem),
      .outReady (outReady)
   );

   always #4 gclk = ~gclk;

   // Consumer stalls about half the time until the drain phase
   always @(posedge gclk) begin
      outReady <= draining || (($random(seed) & 32'd1) != 32'd0);
   end

   // Taken in bit 1 and delay in bit 0 for one command
   function automatic logic [1:0] branchOutcome(branchCmd c);
      dataWord op;
      logic    hit;
      op = (c.fwd == fwdAlu) ? c.aluResult : (c.fwd == fwdLoad) ? c.loadData : c.regA;
      case (c.rd[2:0])
         3'd0:    hit = ($signed(op) == 0);
         3'd1:    hit = ($signed(op) != 0);
         3'd2:    hit = ($signed(op) < 0);
         3'd3:    hit = ($signed(op) <= 0);
         3'd4:    hit = ($signed(op) > 0);
         3'd5:    hit = ($signed(op) >= 0);
         default: hit = 1'b0;
      endcase
      if (c.opc == opBru || c.opc == opBrui)
         return {1'b1, c.ra[4]};
      if (c.opc == opRtd)
         return 2'b11;
      if (c.opc == opBcc || c.opc == opBcci)
         return {hit, c.rd[4]};
      return 2'b00;
   endfunction

   task automatic compareField(string name, logic [31:0] expV, logic [31:0] actV);
      assert (actV === expV)
         else begin
            checkErrs++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, expV, actV);
         end
   endtask

   // Replays every step including empty ones and checks each output transfer
   always @(posedge gclk) begin
      branchCmd        c;
      logic [1:0]      td;
      logic            kill;
      logic            bnd;
      logic [ixW-1:0]  romIx;
      fetchItem        want;
      if (!grst && cmdReady) begin
         c = cmdValid ? cmd : '0;
         td = branchOutcome(c);
         if (cmdValid) begin
            assert (td[1] === takenTbl[acceptCount])
               else begin
                  checkErrs++;
                  $display("Table row %0d disagrees with the branch rules", acceptCount);
               end
            acceptCount++;
         end
         kill = (td == 2'b10) || mTakenPrev;
         // Killed commands count as no-ops for the boundary
         bnd = !((((td[1] || c.opc == opImm)) && !kill) || mTakenPrev);
         romIx = ixW'({2'b00, mPc} % romDepth);
         if (!mFirstStep && !kill)
            expQ.push_back('{pc: mPc, pcLink: mLink, instr: romImage[romIx], boundary: bnd});
         mLink = mPc;
         mPc = mFetch;
         mFetch = td[1] ? c.target : mFetch + 30'd1;
         mTakenPrev = td[1];
         mFirstStep = 1'b0;
      end
      if (!grst && outValid && outReady) begin
         if (expQ.size() == 0) begin
            checkErrs++;
            $display("Item delivered at t=%0t with nothing expected", $time);
         end else begin
            want = expQ.pop_front();
            compareField("pc", {2'b00, want.pc}, {2'b00, outItem.pc});
            compareField("pcLink", {2'b00, want.pcLink}, {2'b00, outItem.pcLink});
            compareField("instr", want.instr, outItem.instr);
            compareField("boundary", {31'd0, want.boundary}, {31'd0, outItem.boundary});
         end
         checkedCount++;
      end
      // Ready only drops when the output queue is full
      if (!grst && !cmdReady) begin
         readyLowCycles++;
         assert (outValid)
            else begin
               checkErrs++;
               $display("cmdReady low at t=%0t while no item waits", $time);
            end
      end
   end

   // Operand goes to the field named by fwd, the other two get its complement
   task automatic addRow(opcodeT opc, regAddr rd, regAddr ra, fwdSel fwd, dataWord opnd,
                         pcWord target, logic taken);
      branchCmd c;
      c = '{opc: opc, rd: rd, ra: ra, fwd: fwd, regA: ~opnd, aluResult: ~opnd,
            loadData: ~opnd, target: target};
      case (fwd)
         fwdAlu:  c.aluResult = opnd;
         fwdLoad: c.loadData = opnd;
         default: c.regA = opnd;
      endcase
      cmdTbl.push_back(c);
      takenTbl.push_back(taken);
   endtask

   task automatic waitAccept(int row);
      int n;
      n = 0;
      do begin
         @(posedge gclk);
         n++;
      end while (!cmdReady && n < stepLimit);
      if (!cmdReady) begin
         timedOut = 1'b1;
         timeoutErrs++;
         $display("Timeout waiting for cmdReady on table row %0d", row);
      end
   endtask

   task automatic waitDrain(int goal);
      int n;
      n = 0;
      while (checkedCount < goal && n < stepLimit) begin
         @(negedge gclk);
         n++;
      end
      if (checkedCount < goal) begin
         timeoutErrs++;
         $display("Timeout draining output, %0d of %0d items seen", checkedCount, goal);
      end
   endtask

   initial begin
      gclk = 1'b0;
      grst = 1'b1;
      cmdValid = 1'b0;
      cmd = '0;
      outReady = 1'b0;
      seed = 32'h899a8684;
      {draining, timedOut, mTakenPrev} = 3'b000;
      mFirstStep = 1'b1;
      {mFetch, mPc, mLink} = '0;
      {checkErrs, timeoutErrs, readyLowCycles, acceptCount, checkedCount} = '0;
      $readmemh("program.hex", romImage);
      addRow(6'o00, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);   // sequential steps
      addRow(6'o00, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);
      addRow(opBru, 5'h00, 5'h00, fwdReg, zeroV, 30'd12, 1'b1);  // no delay slot
      addRow(6'o00, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);
      addRow(opBrui, 5'h00, 5'h10, fwdReg, zeroV, 30'd3, 1'b1);  // delay slot kept
      addRow(6'o00, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);
      addRow(opRtd, 5'h00, 5'h00, fwdReg, zeroV, 30'd18, 1'b1);
      addRow(6'o00, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);
      addRow(opImm, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);   // prefix clears boundary
      addRow(opBcci, 5'h00, 5'h00, fwdReg, zeroV, 30'd5, 1'b1);
      addRow(opBcc, 5'h00, 5'h00, fwdAlu, posV, 30'd9, 1'b0);
      addRow(opBcci, 5'h11, 5'h00, fwdLoad, negV, 30'd20, 1'b1); // ne with delay
      addRow(opBcc, 5'h01, 5'h00, fwdAlu, zeroV, 30'd9, 1'b0);
      addRow(opBcc, 5'h02, 5'h00, fwdReg, negV, 30'd1, 1'b1);
      addRow(opBcci, 5'h02, 5'h00, fwdLoad, posV, 30'd9, 1'b0);
      addRow(opBcc, 5'h02, 5'h00, fwdAlu, zeroV, 30'd9, 1'b0);   // lt is strict
      addRow(opBcc, 5'h13, 5'h00, fwdLoad, zeroV, 30'd14, 1'b1); // le with delay
      addRow(opBcc, 5'h03, 5'h00, fwdReg, posV, 30'd9, 1'b0);
      addRow(opBcci, 5'h14, 5'h00, fwdAlu, posV, 30'd7, 1'b1);
      addRow(opBcc, 5'h04, 5'h00, fwdAlu, negV, 30'd9, 1'b0);
      addRow(opBcci, 5'h04, 5'h00, fwdLoad, zeroV, 30'd9, 1'b0); // gt is strict
      addRow(opBcc, 5'h05, 5'h00, fwdLoad, negV, 30'd9, 1'b0);
      addRow(opBcci, 5'h05, 5'h00, fwdReg, zeroV, 30'd22, 1'b1);
      addRow(opBcc, 5'h06, 5'h00, fwdReg, zeroV, 30'd2, 1'b0);   // codes 6 and 7 never go
      addRow(opBcc, 5'h07, 5'h00, fwdAlu, negV, 30'd2, 1'b0);
      addRow(6'o00, 5'h00, 5'h00, fwdReg, zeroV, 30'd0, 1'b0);
      repeat (3) @(posedge gclk);
      grst <= 1'b0;
      for (int i = 0; i < cmdTbl.size() && !timedOut; i++) begin
         cmdValid <= 1'b1;
         cmd <= cmdTbl[i];
         waitAccept(i);
      end
      cmdValid <= 1'b0;
      draining <= 1'b1;
      @(negedge gclk);
      drainGoal = checkedCount + expQ.size();
      if (!timedOut)
         waitDrain(drainGoal);
      assert (readyLowCycles > 0)
         else begin
            checkErrs++;
            $display("cmdReady never fell under back-pressure");
         end
      $display("Errors: %0d check, %0d timeout, %0d items compared",
               checkErrs, timeoutErrs, checkedCount);
      if (checkErrs == 0 && timeoutErrs == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: compile.f
hdl/fetchPkg.sv
hdl/branchCond.sv
hdl/branchPcUnit.sv
hdl/instrRom.sv
hdl/fetchOutput.sv
hdl/branchFrontEnd.sv
tb/frontEndTb.sv

// File: run.sh
#!/bin/sh
# Build the front-end testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f compile.f --top-module frontEndTb -o frontEndSim
out=$(./obj_dir/frontEndSim)
echo "$out"
if echo "$out" | grep -q "^Result: PASSED$"; then
   exit 0
fi
exit 1

// File: program.hex
// One 32-bit instruction word per line, word address 0 upward
20600001
30210004
20c00010
11043000
e8830008
a0a50ff0
30c6ffff
80e73800
b0000012
31080020
d9284000
3129fffc
bc03fff8
2140000a
00a56000
e96b0004
b8100030
898c6800
39adfff0
f9cd0000
b60f0008
41ef7000
32100001
b800ffa4
